//--- flist.f
src/csb_pkg.sv
src/engine_if.sv
src/cmd_fetch.sv
src/cmd_fifo.sv
src/csb.sv
src/conv_pool_engine.sv
src/csb_top.sv
testbench/tb_csb_top.sv

//--- Makefile
TOP := tb_csb_top
SRCS := $(wildcard src/*.sv testbench/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_csb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csb_top;

    localparam int MAX_DESC   = 16;
    localparam int MEM_WORDS  = MAX_DESC * 8;
    localparam int CHAN_GROUP = 16;    // Output channels per surface pass

    logic        clk;
    logic        rst;
    logic        i_op_en;
    logic [7:0]  i_cmd_count;
    logic        o_wb_cyc;
    logic        o_wb_stb;
    logic [31:0] o_wb_adr;
    logic [31:0] i_wb_dat = 32'd0;     // Driven by the memory model only
    logic        i_wb_ack = 1'b0;
    logic        o_out_valid;
    logic [2:0]  o_out_op_type;
    logic [29:0] o_out_data_addr;
    logic [31:0] o_out_res_addr;
    logic        o_irq;
    logic        o_busy;

    // Command memory plus the fields that the reference works from
    logic [31:0] cmd_mem [MEM_WORDS];
    int          ndesc;
    logic [2:0]  d_op     [MAX_DESC];
    int          d_stride [MAX_DESC];
    int          d_opnum  [MAX_DESC];
    int          d_chan   [MAX_DESC];
    int          d_side   [MAX_DESC];
    int          d_kernel [MAX_DESC];
    logic [29:0] d_data   [MAX_DESC];
    logic [31:0] d_res    [MAX_DESC];
    logic [64:0] exp_q [$];            // {op type, data addr, res addr}

    // Error counts of the main flow, monitor and memory model
    int main_err;
    int mon_err;
    int wb_err;
    int pass_count;
    int fail_count;
    logic timed_out;

    // Memory model state
    logic [31:0] lfsr = 32'h62e;
    logic [31:0] rnd;
    logic        beat_open;
    int          ack_wait;
    int          beat_idx;              // Expected word address of the next beat

    // Monitor state
    int          out_idx;
    logic        irq_seen;
    logic [64:0] beat;

    csb_top i_csb_top (
        .clk, .rst, .i_op_en, .i_cmd_count,
        .o_wb_cyc, .o_wb_stb, .o_wb_adr, .i_wb_dat, .i_wb_ack,
        .o_out_valid, .o_out_op_type, .o_out_data_addr, .o_out_res_addr,
        .o_irq, .o_busy
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;         // 8 ns period
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp, inout int errs);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            errs = errs + 1;
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};    // One step per bit
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] adr);
        if (adr < 32'(MEM_WORDS))
            return cmd_mem[int'(adr)];
        return ~adr;                   // Outside the descriptor table
    endfunction

    function automatic int outputs_of(input int d);
        return d_side[d] * d_side[d] * (d_chan[d] / CHAN_GROUP);
    endfunction

    // Output k of descriptor d from its row and column in the surface
    function automatic logic [64:0] expected_beat(input int d, input int k);
        int          pix;
        int          row;
        int          col;
        int          row_step;
        logic [29:0] data;
        logic [31:0] res;
        pix      = k % (d_side[d] * d_side[d]);   // Restarts per channel group
        row      = pix / d_side[d];
        col      = pix % d_side[d];
        row_step = (d_side[d] - 1) * d_stride[d] + d_opnum[d];
        data     = d_data[d] + 30'(row * row_step * 16 + col * d_stride[d] * 16);
        res      = d_res[d] + 32'(k * 16);         // Never rewinds
        return {d_op[d], data, res};
    endfunction

    task automatic clear_descs();
        ndesc = 0;
        for (int i = 0; i < MEM_WORDS; i++)
            cmd_mem[i] = 32'hc3c3_0000 | 32'(i);
    endtask

    task automatic add_desc(input logic [2:0] op, input int stride, input int op_num,
                            input int chan, input int side, input int kernel,
                            input logic [31:0] data, input logic [31:0] res);
        int base;
        int in_side;
        base    = ndesc * 8;
        in_side = (side - 1) * stride + kernel;
        cmd_mem[base]     = {16'(op_num), 4'd0, 4'(stride), 3'd0, 1'b0, 1'b0, op};
        cmd_mem[base + 1] = 32'h0004_0001;   // Corner and side counts
        cmd_mem[base + 2] = {16'(chan), 16'd3};
        cmd_mem[base + 3] = {8'd0, 8'(kernel), 8'(side), 8'(in_side)};
        cmd_mem[base + 4] = {16'(side * side), 16'(in_side * in_side)};
        cmd_mem[base + 5] = 32'h00c0_0000 + 32'(base);
        cmd_mem[base + 6] = data;
        cmd_mem[base + 7] = res;
        d_op[ndesc]     = op;
        d_stride[ndesc] = stride;
        d_opnum[ndesc]  = op_num;
        d_chan[ndesc]   = chan;
        d_side[ndesc]   = side;
        d_kernel[ndesc] = kernel;
        d_data[ndesc]   = data[29:0];
        d_res[ndesc]    = res;
        ndesc = ndesc + 1;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst     = 1'b1;
        i_op_en = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_test(input int num, input string name);
        int limit;
        int cycles;
        int errs_before;
        int n;
        exp_q.delete();
        limit = 0;
        for (int d = 0; d < ndesc; d++) begin
            n = outputs_of(d);
            for (int k = 0; k < n; k++)
                exp_q.push_back(expected_beat(d, k));
            limit = limit + n * (d_kernel[d] + 2) + 40;
        end
        errs_before = main_err + mon_err + wb_err;
        apply_reset();
        check_value("wb_cyc after reset", 64'(o_wb_cyc), 64'd0, main_err);
        check_value("irq after reset", 64'(o_irq), 64'd0, main_err);
        check_value("busy after reset", 64'(o_busy), 64'd0, main_err);
        check_value("out_valid after reset", 64'(o_out_valid), 64'd0, main_err);
        i_cmd_count = 8'(ndesc);
        i_op_en     = 1'b1;             // One cycle start pulse
        @(negedge clk);
        i_op_en = 1'b0;
        cycles  = 0;
        while (!o_irq && cycles < limit) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (!o_irq)
                check_value("busy during run", 64'(o_busy), 64'd1, main_err);
        end
        if (!o_irq) begin
            $display("test %0d %s: no interrupt within %0d cycles, run stopped",
                     num, name, limit);
            timed_out  = 1'b1;
            fail_count = fail_count + 1;
        end else begin
            repeat (6) @(negedge clk);  // Irq must hold with no late beats
            check_value("output count", 64'(out_idx), 64'(exp_q.size()), main_err);
            check_value("irq held", 64'(o_irq), 64'd1, main_err);
            check_value("busy after run", 64'(o_busy), 64'd0, main_err);
            if (main_err + mon_err + wb_err == errs_before) begin
                pass_count = pass_count + 1;
                $display("test %0d %s: passed, %0d outputs", num, name, out_idx);
            end else begin
                fail_count = fail_count + 1;
                $display("test %0d %s: failed", num, name);
            end
        end
    endtask

    // Wishbone slave acking after 0 to 3 wait cycles
    always @(negedge clk) begin
        if (rst)
            beat_idx = 0;
        if (rst || !(o_wb_cyc && o_wb_stb)) begin
            i_wb_ack  = 1'b0;
            beat_open = 1'b0;
        end else begin
            if (!beat_open) begin
                take_bits(2, rnd);
                ack_wait  = int'(rnd[1:0]);
                beat_open = 1'b1;
            end
            if (ack_wait == 0) begin
                check_value("wishbone word address", 64'(o_wb_adr), 64'(beat_idx), wb_err);
                i_wb_dat  = mem_word(o_wb_adr);
                i_wb_ack  = 1'b1;
                beat_open = 1'b0;
                beat_idx  = beat_idx + 1;
            end else begin
                i_wb_ack = 1'b0;
                ack_wait = ack_wait - 1;
            end
        end
    end

    // Output monitor sampling on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            out_idx  = 0;
            irq_seen = 1'b0;
        end else begin
            if (o_out_valid) begin
                if (out_idx >= exp_q.size()) begin
                    $display("%0d ns: output beat %0d arrived but only %0d were expected",
                             $time, out_idx + 1, exp_q.size());
                    mon_err = mon_err + 1;
                end else begin
                    beat = exp_q[out_idx];
                    check_value("op type", 64'(o_out_op_type), 64'(beat[64:62]), mon_err);
                    check_value("data address", 64'(o_out_data_addr), 64'(beat[61:32]),
                                mon_err);
                    check_value("result address", 64'(o_out_res_addr), 64'(beat[31:0]),
                                mon_err);
                end
                out_idx = out_idx + 1;
            end
            if (o_irq && !irq_seen) begin
                irq_seen = 1'b1;       // Rises with the last beat at the earliest
                check_value("outputs at irq", 64'(out_idx), 64'(exp_q.size()), mon_err);
            end else if (irq_seen && !o_irq) begin
                $display("%0d ns: interrupt dropped before reset", $time);
                mon_err  = mon_err + 1;
                irq_seen = 1'b0;
            end
            if (o_irq)
                check_value("busy while irq", 64'(o_busy), 64'd0, mon_err);
        end
    end

    initial begin
        rst         = 1'b1;
        i_op_en     = 1'b0;
        i_cmd_count = 8'd0;
        main_err    = 0;
        mon_err     = 0;
        wb_err      = 0;
        pass_count  = 0;
        fail_count  = 0;
        timed_out   = 1'b0;

        clear_descs();
        add_desc(3'd1, 1, 6, 16, 4, 1, 32'h0000_0100, 32'h0000_8000);
        run_test(1, "single 1x1 convolution");

        if (!timed_out) begin
            clear_descs();
            add_desc(3'd4, 2, 5, 32, 3, 2, 32'h0000_2000, 32'h0001_0000);
            run_test(2, "max-pool with two channel passes");
        end

        if (!timed_out) begin
            clear_descs();
            add_desc(3'd2, 1, 4, 16, 2, 3, 32'h0000_0400, 32'h0002_0000);
            add_desc(3'd4, 2, 7, 16, 3, 2, 32'h0000_0800, 32'h0003_0000);
            add_desc(3'd5, 1, 3, 48, 2, 4, 32'h0000_0c00, 32'h0004_0000);
            run_test(3, "conv, max-pool and average-pool back to back");
        end

        // Twelve descriptors overrun the FIFO depth
        if (!timed_out) begin
            clear_descs();
            for (int i = 0; i < 12; i++)
                add_desc(3'((i % 5) + 1), (i % 3) + 1, i + 2, CHAN_GROUP * (1 + i % 2),
                         4 + i % 2, 2 + i % 3, 32'h0000_1000 + 32'(i) * 32'h400,
                         32'h2000_0000 + 32'(i) * 32'h0001_0000);
            run_test(4, "twelve descriptors with back-pressure");
        end

        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && main_err + mon_err + wb_err == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/csb_top.sv
`timescale 1ns/1ps
`default_nettype none

module csb_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_op_en,
    input  logic [7:0]         i_cmd_count,
    output logic               o_wb_cyc,
    output logic               o_wb_stb,
    output csb_pkg::word_t     o_wb_adr,
    input  csb_pkg::word_t     i_wb_dat,
    input  logic               i_wb_ack,
    output logic               o_out_valid,
    output csb_pkg::op_type_e  o_out_op_type,
    output csb_pkg::addr_t     o_out_data_addr,
    output csb_pkg::res_addr_t o_out_res_addr,
    output logic               o_irq,
    output logic               o_busy
);

    logic               push;
    csb_pkg::word_t     push_data;
    logic               pop;
    csb_pkg::word_t     pop_data;
    csb_pkg::fifo_cnt_t fifo_count;
    logic               fifo_empty;
    logic               fetch_busy;
    logic               fetch_start;
    csb_pkg::addr_t     data_addr;
    csb_pkg::res_addr_t res_addr;
    csb_pkg::op_type_e  op_type;

    engine_if eng_if ();

    cmd_fetch i_cmd_fetch (
        .clk, .rst,
        .i_start      (fetch_start),
        .i_cmd_count,
        .i_fifo_count (fifo_count),
        .o_wb_cyc, .o_wb_stb, .o_wb_adr, .i_wb_dat, .i_wb_ack,
        .o_push       (push),
        .o_push_data  (push_data),
        .o_busy       (fetch_busy)
    );

    cmd_fifo i_cmd_fifo (
        .clk, .rst,
        .i_push      (push),
        .i_push_data (push_data),
        .i_pop       (pop),
        .o_pop_data  (pop_data),
        .o_count     (fifo_count),
        .o_empty     (fifo_empty)
    );

    csb i_csb (
        .clk, .rst, .i_op_en,
        .i_fifo_count  (fifo_count),
        .i_fifo_empty  (fifo_empty),
        .i_cmd_word    (pop_data),
        .i_fetch_busy  (fetch_busy),
        .o_pop         (pop),
        .eng           (eng_if.csb),
        .o_fetch_start (fetch_start),
        .o_data_addr   (data_addr),
        .o_weight_addr (),            // Weight stream not modeled here
        .o_res_addr    (res_addr),
        .o_op_type     (op_type),
        .o_busy, .o_irq
    );

    conv_pool_engine i_engine (
        .clk, .rst,
        .eng (eng_if.engine)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            o_out_valid <= 1'b0;
        else
            o_out_valid <= eng_if.valid;
    end

    // Addresses sampled in the valid cycle, before csb steps them
    always_ff @(posedge clk) begin
        if (eng_if.valid) begin
            o_out_op_type   <= op_type;
            o_out_data_addr <= data_addr;
            o_out_res_addr  <= res_addr;
        end
    end

endmodule

`default_nettype wire

//--- src/conv_pool_engine.sv
`timescale 1ns/1ps
`default_nettype none

// Timing model of the conv/pool datapath, no arithmetic
module conv_pool_engine (
    input  logic     clk,
    input  logic     rst,
    engine_if.engine eng
);

    csb_pkg::side_t cnt;     // Cycles left until next output
    csb_pkg::side_t period;

    assign period = (eng.kernel_size == 8'd0) ? 8'd1 : eng.kernel_size;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (!eng.ready) begin
            cnt <= period;            // First pulse kernel_size cycles after ready
        end else if (cnt == '0) begin
            cnt <= period - 8'd1;     // Then one every kernel_size cycles
        end else begin
            cnt <= cnt - 8'd1;
        end
    end

    assign eng.valid = eng.ready && (cnt == '0);

    // Dispatch fields must not change under a running operation
    a_dispatch_stable : assert property (@(posedge clk) disable iff (rst)
        eng.ready && $past(eng.ready) |->
            $stable({eng.op_type, eng.kernel_size, eng.stride, eng.op_num}))
        else $error("conv_pool_engine: dispatch fields changed while ready");

endmodule

`default_nettype wire

//--- src/csb.sv
`timescale 1ns/1ps
`default_nettype none

module csb (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_op_en,
    input  csb_pkg::fifo_cnt_t i_fifo_count,
    input  logic               i_fifo_empty,
    input  csb_pkg::word_t     i_cmd_word,
    input  logic               i_fetch_busy,
    output logic               o_pop,
    engine_if.csb              eng,
    output logic               o_fetch_start,
    output csb_pkg::addr_t     o_data_addr,
    output csb_pkg::addr_t     o_weight_addr,
    output csb_pkg::res_addr_t o_res_addr,
    output csb_pkg::op_type_e  o_op_type,
    output logic               o_busy,
    output logic               o_irq
);

    csb_pkg::csb_state_e state;
    csb_pkg::csb_state_e state_nxt;
    logic [$clog2(csb_pkg::CMD_BURST_LEN)-1:0] burst_idx;

    // Unpacked descriptor fields
    csb_pkg::op_type_e  op_type;
    logic [3:0]         stride;
    csb_pkg::op_num_t   op_num;   // Center count, row jump in data words
    csb_pkg::surf_t     out_chan;
    csb_pkg::side_t     out_side;
    csb_pkg::side_t     kernel;
    csb_pkg::addr_t     weight_start;
    csb_pkg::addr_t     data_start;
    csb_pkg::res_addr_t res_start;

    // Output progress
    csb_pkg::side_t     width_cnt;
    csb_pkg::surf_t     surf_cnt;
    csb_pkg::surf_t     chan_cnt;   // Steps by PARA
    csb_pkg::surf_t     side_sq;

    logic pop_go;
    logic cmd_done;
    logic more_cmds;
    logic row_end;
    logic surf_end;
    logic last_out;

    assign side_sq   = csb_pkg::surf_t'(out_side) * csb_pkg::surf_t'(out_side);
    assign row_end   = width_cnt == out_side - 8'd1;
    assign surf_end  = surf_cnt == side_sq - 16'd1;
    assign last_out  = eng.valid && surf_end &&
                       (chan_cnt + csb_pkg::surf_t'(csb_pkg::PARA) >= out_chan);
    assign more_cmds = !i_fifo_empty || i_fetch_busy;

    // Burst starts only with a whole descriptor present
    assign pop_go   = (state == csb_pkg::ST_CMD_GET) && ((burst_idx != '0) ||
                      (i_fifo_count >= csb_pkg::fifo_cnt_t'(csb_pkg::CMD_BURST_LEN)));
    assign cmd_done = pop_go && (&burst_idx);

    always_comb begin
        state_nxt = state;
        case (state)
            csb_pkg::ST_IDLE:
                if (i_op_en) state_nxt = csb_pkg::ST_CMD_GET;
            csb_pkg::ST_CMD_GET: begin
                if (cmd_done)
                    state_nxt = csb_pkg::ST_CMD_ISSUE;
                else if (burst_idx == '0 && !more_cmds)
                    state_nxt = csb_pkg::ST_FINISH;     // Zero descriptor run
            end
            csb_pkg::ST_CMD_ISSUE:
                state_nxt = csb_pkg::ST_OP_RUN;
            csb_pkg::ST_OP_RUN:
                if (last_out) state_nxt = more_cmds ? csb_pkg::ST_CMD_GET : csb_pkg::ST_FINISH;
            default:
                state_nxt = csb_pkg::ST_IDLE;           // Finish included
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= csb_pkg::ST_IDLE;
            burst_idx <= '0;
            eng.ready <= 1'b0;
            o_irq     <= 1'b0;
            width_cnt <= '0;
            surf_cnt  <= '0;
            chan_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (state_nxt == csb_pkg::ST_FINISH)
                o_irq <= 1'b1;                  // Sticky until reset
            if (pop_go)
                burst_idx <= burst_idx + 1'b1;  // Wraps to 0 after the last word
            if (state == csb_pkg::ST_CMD_ISSUE) begin
                eng.ready <= 1'b1;
                width_cnt <= '0;
                surf_cnt  <= '0;
                chan_cnt  <= '0;
            end else if (eng.valid) begin
                if (surf_end) begin             // Next channel group
                    surf_cnt  <= '0;
                    width_cnt <= '0;
                    chan_cnt  <= chan_cnt + csb_pkg::surf_t'(csb_pkg::PARA);
                end else begin
                    surf_cnt  <= surf_cnt + 16'd1;
                    width_cnt <= row_end ? '0 : width_cnt + 8'd1;
                end
                if (last_out)
                    eng.ready <= 1'b0;          // Low the cycle after the last output
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_go) begin
            case (burst_idx)
                csb_pkg::W_HEAD: begin
                    op_type <= csb_pkg::op_type_e'(i_cmd_word[2:0]);
                    stride  <= i_cmd_word[11:8];
                    op_num  <= i_cmd_word[31:16];
                end
                csb_pkg::W_CHAN:   out_chan <= i_cmd_word[31:16];
                csb_pkg::W_SIDE: begin
                    out_side <= i_cmd_word[15:8];
                    kernel   <= i_cmd_word[23:16];
                end
                csb_pkg::W_WEIGHT: weight_start <= i_cmd_word[29:0];
                csb_pkg::W_DATA:   data_start   <= i_cmd_word[29:0];
                csb_pkg::W_RES:    res_start    <= i_cmd_word;
                default: ;  // Padding, corner/side counts and input sizes not modeled
            endcase
        end
        if (state == csb_pkg::ST_CMD_ISSUE) begin
            o_data_addr   <= data_start;
            o_weight_addr <= weight_start;
            o_res_addr    <= res_start;
        end else if (eng.valid) begin
            o_res_addr <= o_res_addr + csb_pkg::res_addr_t'(csb_pkg::ADDR_STEP);
            if (surf_end)
                o_data_addr <= data_start;     // Rescan input for next group
            else if (row_end)
                o_data_addr <= o_data_addr +
                    csb_pkg::addr_t'(op_num) * csb_pkg::addr_t'(csb_pkg::ADDR_STEP);
            else
                o_data_addr <= o_data_addr +
                    csb_pkg::addr_t'(stride) * csb_pkg::addr_t'(csb_pkg::ADDR_STEP);
        end
    end

    assign o_pop           = pop_go;
    assign o_fetch_start   = (state == csb_pkg::ST_IDLE) && i_op_en;
    assign o_busy          = (state != csb_pkg::ST_IDLE) && (state != csb_pkg::ST_FINISH);
    assign o_op_type       = op_type;
    assign eng.op_type     = op_type;
    assign eng.kernel_size = kernel;
    assign eng.stride      = stride;
    assign eng.op_num      = op_num;

    // Engine output only while an operation is running
    a_valid_in_run : assert property (@(posedge clk) disable iff (rst)
        eng.valid |-> state == csb_pkg::ST_OP_RUN)
        else $error("csb: engine valid outside op_run");

endmodule

`default_nettype wire

//--- src/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_push,
    input  csb_pkg::word_t     i_push_data,
    input  logic               i_pop,
    output csb_pkg::word_t     o_pop_data,   // Show-ahead head word
    output csb_pkg::fifo_cnt_t o_count,
    output logic               o_empty
);

    csb_pkg::word_t                   mem [csb_pkg::FIFO_DEPTH];
    logic [csb_pkg::FIFO_PTR_W-1:0]   wr_ptr;
    logic [csb_pkg::FIFO_PTR_W-1:0]   rd_ptr;
    logic                             full;
    logic                             do_push;
    logic                             do_pop;

    assign full    = o_count == csb_pkg::fifo_cnt_t'(csb_pkg::FIFO_DEPTH);
    assign o_empty = o_count == '0;
    assign do_push = i_push && !full;    // Overflow is dropped
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= i_push_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // Power of two depth, wraps freely
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: ;                 // Both or neither keep the count
            endcase
        end
    end

    assign o_pop_data = mem[rd_ptr];

    a_no_overflow : assert property (@(posedge clk) disable iff (rst)
        i_push |-> !full)
        else $error("cmd_fifo: push while full");

    a_no_underflow : assert property (@(posedge clk) disable iff (rst)
        i_pop |-> !o_empty)
        else $error("cmd_fifo: pop while empty");

endmodule

`default_nettype wire

//--- src/cmd_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fetch (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_start,
    input  logic [7:0]         i_cmd_count,   // Descriptors to read
    input  csb_pkg::fifo_cnt_t i_fifo_count,
    output logic               o_wb_cyc,
    output logic               o_wb_stb,
    output csb_pkg::word_t     o_wb_adr,      // Word index
    input  csb_pkg::word_t     i_wb_dat,
    input  logic               i_wb_ack,
    output logic               o_push,
    output csb_pkg::word_t     o_push_data,
    output logic               o_busy
);

    logic           busy;
    logic           cyc;
    csb_pkg::word_t target;   // Total beats for this run
    csb_pkg::word_t adr;      // Word of the current or next beat
    logic           room1;    // Space for one outstanding word
    logic           room2;    // Space for the acked word plus one more
    logic           last_beat;

    assign room1     = i_fifo_count < csb_pkg::fifo_cnt_t'(csb_pkg::FIFO_DEPTH);
    assign room2     = i_fifo_count <= csb_pkg::fifo_cnt_t'(csb_pkg::FIFO_DEPTH - 2);
    assign last_beat = (adr + 32'd1) == target;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            cyc    <= 1'b0;
            target <= '0;
            adr    <= '0;
        end else if (!busy) begin
            if (i_start) begin
                busy   <= i_cmd_count != 8'd0;  // Nothing to do for zero descriptors
                target <= csb_pkg::word_t'(i_cmd_count) *
                          csb_pkg::word_t'(csb_pkg::CMD_BURST_LEN);
                adr    <= '0;
            end
        end else if (cyc) begin
            if (i_wb_ack) begin
                adr <= adr + 32'd1;
                if (last_beat) begin
                    busy <= 1'b0;   // Done after final ack
                    cyc  <= 1'b0;
                end else begin
                    cyc  <= room2;  // Back to back if the FIFO allows
                end
            end
        end else if (room1) begin
            cyc <= 1'b1;            // Resume once space frees up
        end
    end

    assign o_wb_cyc    = cyc;
    assign o_wb_stb    = cyc;   // Classic cycle, one beat per cyc
    assign o_wb_adr    = adr;
    assign o_push      = cyc && i_wb_ack;
    assign o_push_data = i_wb_dat;  // Taken in the ack cycle
    assign o_busy      = busy;

    // A started beat must be held until the slave acks it
    a_stb_held : assert property (@(posedge clk) disable iff (rst)
        $fell(o_wb_stb) |-> $past(i_wb_ack))
        else $error("cmd_fetch: stb dropped without ack");

endmodule

`default_nettype wire

//--- src/engine_if.sv
`timescale 1ns/1ps
`default_nettype none

// Dispatch bundle between sequencer and compute engine
interface engine_if;

    logic               ready;        // Level, engine runs while high
    csb_pkg::op_type_e  op_type;      // Held while ready
    csb_pkg::side_t     kernel_size;  // Sets output pulse spacing
    logic [3:0]         stride;
    csb_pkg::op_num_t   op_num;
    logic               valid;        // One pulse per output pixel

    modport csb (
        output ready,
        output op_type,
        output kernel_size,
        output stride,
        output op_num,
        input  valid
    );

    modport engine (
        input  ready,
        input  op_type,
        input  kernel_size,
        input  stride,
        input  op_num,
        output valid
    );

endinterface

`default_nettype wire

//--- src/csb_pkg.sv
`default_nettype none

package csb_pkg;

    localparam int CMD_BURST_LEN = 8;   // Words per layer descriptor
    localparam int PARA          = 16;  // Output channels finished per surface pass
    localparam int FIFO_DEPTH    = 64;  // Command FIFO words
    localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W    = $clog2(FIFO_DEPTH + 1);
    localparam int ADDR_STEP     = 16;  // Byte step per output

    // Descriptor word index within a burst
    localparam logic [2:0] W_HEAD   = 3'd0;  // Type, padding, stride, op_num
    localparam logic [2:0] W_CHAN   = 3'd2;  // In/out channel size
    localparam logic [2:0] W_SIDE   = 3'd3;  // In side, out side, kernel
    localparam logic [2:0] W_WEIGHT = 3'd5;
    localparam logic [2:0] W_DATA   = 3'd6;
    localparam logic [2:0] W_RES    = 3'd7;

    typedef logic [31:0]           word_t;      // Command word
    typedef logic [29:0]           addr_t;      // Data / weight address
    typedef logic [31:0]           res_addr_t;  // Write-back address
    typedef logic [15:0]           op_num_t;
    typedef logic [7:0]            side_t;      // Side or kernel size
    typedef logic [15:0]           surf_t;      // Surface or channel size
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        CONV1   = 3'd1,
        CONV3   = 3'd2,
        CONV3P  = 3'd3,  // 3x3 with padding
        MAXPOOL = 3'd4,
        AVEPOOL = 3'd5
    } op_type_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CMD_GET,    // Pop and unpack one descriptor
        ST_CMD_ISSUE,  // Load addresses, raise ready
        ST_OP_RUN,     // Follow engine outputs
        ST_FINISH
    } csb_state_e;

endpackage

`default_nettype wire
